/* Makefile */
# Verilator build and run of the M92 bus controller testbench

SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_m92_bus_ctrl: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_m92_bus_ctrl -f vlog.f

run: obj_dir/Vtb_m92_bus_ctrl
	./obj_dir/Vtb_m92_bus_ctrl

clean:
	rm -rf obj_dir

/* testbench/m92_stimulus.txt */
# R addr rdata_expected fill_requests | W addr sel wdata | P 0 0 0
# I port rdata_expected kick_harness | O port wdata sys_flags_expected (all values hex)
R 00100 A543 1
R 00104 A541 0
R 00106 A540 0
R 00103 00A5 0
R 4A13A F55E 1
R 00100 A543 0
R 10100 2543 1
R 00104 A541 1
O 20 03 00
R 80010 A5CB 1
R 9FFFE 5A3C 1
O 20 0A 00
R 81234 ACD9 1
R 81235 00AC 0
O 20 03 00
R 80010 A5CB 0
O 20 00 00
R 80016 A5C8 1
R 00100 A543 0
W E0000 3 1234
R E0000 1234 0
W E0001 1 00AB
R E0000 AB34 0
R E0001 00AB 0
W E0002 3 BEEF
W E0002 1 5566
R E0002 BE66 0
W E0002 2 7788
R E0002 7766 0
R E0003 0077 0
W EFFFE 3 C0DE
W EFFFF 2 0012
R EFFFE C0DE 0
W EFFFF 3 0012
R EFFFE 12DE 0
R A0000 FFFF 0
R DFFFE FFFF 0
R F0000 FFFF 0
R A0001 00FF 0
I 00 7C 0
I 01 B3 0
I 02 F9 0
I 03 C3 0
I 04 18 0
I 05 7E 0
I 06 50 0
I 07 A9 0
I 10 FF 0
I 00 5C 1
I 01 B3 1
I 02 F9 1
I 04 18 1
I 06 FF 1
I 07 D3 1
O 02 5A 5A
O 02 81 81
P 0 0 0

/* testbench/tb_m92_bus_ctrl.sv */
// M92 bus controller testbench with clock, reset, SDRAM model, stimulus interpreter and checks
module tb_m92_bus_ctrl
    import m92_io_pkg::*;
();

    logic        clk_sys = 1'b0;
    logic        reset_n;
    logic        mem_read, mem_write, io_read, io_write;
    logic [19:0] mem_addr;
    logic [1:0]  mem_sel;
    logic [15:0] mem_wdata, mem_rdata;
    logic [7:0]  io_addr, io_wdata, io_rdata, sys_flags;
    logic        cpu_ce, cpu_ce_4x, cpu_stall, cpu_paused;
    logic        sdr_req, sdr_rdy;
    logic [24:0] sdr_addr;
    logic [63:0] sdr_dout;
    logic        vpulse, pause_rq, kick_harness;
    logic [3:0]  coin, start_buttons;
    logic [9:0]  p1_in, p2_in, p3_in, p4_in;
    logic [23:0] dip_sw;

    int          req_count;
    logic [24:0] last_req_addr;
    logic [3:0]  bank_shadow;

    m92_bus_ctrl UUT (.*);

    always #20 clk_sys = ~clk_sys;

    // SDRAM word n of a line is its word address XOR a fixed pattern
    function automatic logic [63:0] line_data(input logic [24:0] byte_addr);
        logic [63:0] d;
        logic [23:0] word_addr;
        word_addr = byte_addr[24:1];
        for (int n = 0; n < 4; n++) begin
            d[n*16 +: 16] = (word_addr[15:0] + 16'(n)) ^ 16'hA5C3;
        end
        return d;
    endfunction

    // Line address of a ROM read by the direct and banked address rules
    function automatic logic [24:0] expected_fill_addr(input logic [19:0] addr,
                                                       input logic [3:0] bank_val);
        logic [24:0] full;
        if (addr < 20'h80000) begin
            full = {5'd0, addr};
        end else begin
            full = 25'h80000 + {21'd0, bank_val} * 25'h20000 + {5'd0, addr - 20'h80000};
        end
        return {full[24:3], 3'b000};
    endfunction

    // ========================================================================
    // SDRAM model
    // ========================================================================
    initial begin
        int          delay;
        logic [24:0] pend_addr;
        void'($urandom(32'h721d));
        delay = 0;
        pend_addr = '0;
        req_count = 0;
        last_req_addr = '0;
        sdr_rdy = 1'b0;
        sdr_dout = '0;
        forever begin
            @(negedge clk_sys);
            sdr_rdy = 1'b0;
            if (delay > 0) begin
                delay = delay - 1;
                if (delay == 0) begin
                    sdr_rdy = 1'b1;
                    sdr_dout = line_data(pend_addr);
                end
            end
            if (sdr_req) begin
                req_count = req_count + 1;
                last_req_addr = sdr_addr;
                pend_addr = sdr_addr;
                delay = 1 + int'($urandom % 6);
            end
        end
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic wait_unstalled();
        int cycles;
        cycles = 0;
        while (cpu_stall) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles >= 200) begin
                stop_with_error("Timeout: cpu_stall stayed high for 200 cycles");
            end
        end
    endtask

    task automatic settle_pause(input logic level);
        int cycles;
        cycles = 0;
        while (cpu_paused != level) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles >= 200) begin
                stop_with_error($sformatf("Timeout: cpu_paused did not go to %b in 200 cycles",
                                          level));
            end
        end
    endtask

    task automatic align_to_ce();
        int cycles;
        cycles = 0;
        while (!cpu_ce) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles >= 200) begin
                stop_with_error("Timeout: no cpu_ce pulse within 200 cycles");
            end
        end
    endtask

    // ========================================================================
    // Stimulus operations
    // ========================================================================
    task automatic mem_read_check(input logic [19:0] addr, input logic [15:0] exp_data,
                                  input int exp_reqs);
        int reqs_before;
        reqs_before = req_count;
        mem_addr = addr;
        mem_read = 1'b1;
        @(negedge clk_sys);
        mem_read = 1'b0;
        assert (cpu_stall == (exp_reqs != 0)) else stop_with_error($sformatf(
            "Mismatch at %0t: cpu_stall is %b after the read of %h", $time, cpu_stall, addr));
        wait_unstalled();
        assert (req_count - reqs_before == exp_reqs) else stop_with_error($sformatf(
            "Mismatch at %0t: read of %h made %0d SDRAM requests, expected %0d",
            $time, addr, req_count - reqs_before, exp_reqs));
        if (exp_reqs != 0) begin
            assert (last_req_addr == expected_fill_addr(addr, bank_shadow))
            else stop_with_error($sformatf("Mismatch at %0t: read of %h requested %h, expected %h",
                $time, addr, last_req_addr, expected_fill_addr(addr, bank_shadow)));
        end
        assert (mem_rdata == exp_data) else stop_with_error($sformatf(
            "Mismatch at %0t: read of %h gave %h, expected %h", $time, addr, mem_rdata, exp_data));
    endtask

    task automatic mem_write_op(input logic [19:0] addr, input logic [1:0] sel,
                                input logic [15:0] data);
        mem_addr = addr;
        mem_sel = sel;
        mem_wdata = data;
        mem_write = 1'b1;
        @(negedge clk_sys);
        mem_write = 1'b0;
    endtask

    // I/O read data is combinational within the strobe cycle
    task automatic io_read_check(input logic [7:0] port, input logic [7:0] exp_data,
                                 input logic kick);
        kick_harness = kick;
        io_addr = port;
        io_read = 1'b1;
        @(posedge clk_sys);
        assert (io_rdata == exp_data) else stop_with_error($sformatf(
            "Mismatch at %0t: port %h with kick %b gave %h, expected %h",
            $time, port, kick, io_rdata, exp_data));
        @(negedge clk_sys);
        io_read = 1'b0;
    endtask

    task automatic io_write_check(input logic [7:0] port, input logic [7:0] data,
                                  input logic [7:0] exp_flags);
        io_addr = port;
        io_wdata = data;
        io_write = 1'b1;
        @(negedge clk_sys);
        io_write = 1'b0;
        if (port == BANK_SEL) begin
            bank_shadow = data[3:0];
        end
        assert (sys_flags == exp_flags) else stop_with_error($sformatf(
            "Mismatch at %0t: sys_flags is %h, expected %h", $time, sys_flags, exp_flags));
    endtask

    task automatic pause_check();
        int ce_seen;
        ce_seen = 0;
        pause_rq = 1'b1;
        vpulse = 1'b0;
        repeat (3) @(negedge clk_sys);
        assert (!cpu_paused) else stop_with_error($sformatf(
            "Mismatch at %0t: cpu_paused rose without a vpulse", $time));
        // Vertical pulse together with a strobe must not pause
        vpulse = 1'b1;
        io_addr = 8'h00;
        io_read = 1'b1;
        @(negedge clk_sys);
        io_read = 1'b0;
        assert (!cpu_paused) else stop_with_error($sformatf(
            "Mismatch at %0t: cpu_paused rose during a strobe", $time));
        @(negedge clk_sys);
        vpulse = 1'b0;
        settle_pause(1'b1);
        repeat (2) @(negedge clk_sys);
        for (int i = 0; i < 12; i++) begin
            @(negedge clk_sys);
            ce_seen += int'(cpu_ce);
        end
        assert (ce_seen == 0 && cpu_stall && cpu_paused) else stop_with_error($sformatf(
            "Mismatch at %0t: %0d cpu_ce pulses while paused", $time, ce_seen));
        pause_rq = 1'b0;
        vpulse = 1'b1;
        @(negedge clk_sys);
        assert (cpu_paused) else stop_with_error($sformatf(
            "Mismatch at %0t: pause ended while vpulse was high", $time));
        vpulse = 1'b0;
        settle_pause(1'b0);
    endtask

    task automatic ce_rate_check();
        int ce_total;
        int ce4_total;
        ce_total = 0;
        ce4_total = 0;
        wait_unstalled();
        repeat (2) @(negedge clk_sys);
        align_to_ce();
        for (int i = 0; i < 40; i++) begin
            @(negedge clk_sys);
            ce_total += int'(cpu_ce);
            ce4_total += int'(cpu_ce_4x);
        end
        assert (ce_total == 10 && ce4_total == 40) else stop_with_error($sformatf(
            "Mismatch at %0t: %0d cpu_ce and %0d cpu_ce_4x pulses in 40 cycles",
            $time, ce_total, ce4_total));
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  op;
        logic [31:0] arg_a, arg_b, arg_c;
        reset_n = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_addr = '0;
        mem_sel = 2'b00;
        mem_wdata = '0;
        io_read = 1'b0;
        io_write = 1'b0;
        io_addr = '0;
        io_wdata = '0;
        vpulse = 1'b0;
        pause_rq = 1'b0;
        kick_harness = 1'b0;
        coin = 4'b0101;
        start_buttons = 4'b1010;
        p1_in = 10'h353;
        p2_in = 10'h0AC;
        p3_in = 10'h01F;
        p4_in = 10'h2E6;
        dip_sw = 24'h3C81E7;
        bank_shadow = 4'h0;
        repeat (3) @(negedge clk_sys);
        reset_n = 1'b1;
        @(negedge clk_sys);

        fd = $fopen("testbench/m92_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_error("Could not open testbench/m92_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%c %h %h %h", op, arg_a, arg_b, arg_c);
                if (fields != 4) begin
                    stop_with_error($sformatf("Malformed stimulus line: %s", line));
                end
                case (op)
                    "R": mem_read_check(arg_a[19:0], arg_b[15:0], int'(arg_c));
                    "W": mem_write_op(arg_a[19:0], arg_b[1:0], arg_c[15:0]);
                    "I": io_read_check(arg_a[7:0], arg_b[7:0], arg_c[0]);
                    "O": io_write_check(arg_a[7:0], arg_b[7:0], arg_c[7:0]);
                    "P": pause_check();
                    default: stop_with_error($sformatf("Unknown stimulus operation %c", op));
                endcase
            end
        end
        $fclose(fd);

        ce_rate_check();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* verilog/m92_bus_ctrl.sv */
// CPU bus controller top level with stall FSM, clock enables, ROM cache, memory map and I/O
module m92_bus_ctrl
    import m92_bus_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset_n,

    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [cpu_addr_w-1:0] mem_addr,
    input  logic [1:0]            mem_sel,
    input  logic [cpu_data_w-1:0] mem_wdata,
    output logic [cpu_data_w-1:0] mem_rdata,
    input  logic                  io_read,
    input  logic                  io_write,
    input  logic [7:0]            io_addr,
    input  logic [7:0]            io_wdata,
    output logic [7:0]            io_rdata,
    output logic                  cpu_ce,
    output logic                  cpu_ce_4x,
    output logic                  cpu_stall,

    output logic                  sdr_req,
    output logic [sdr_addr_w-1:0] sdr_addr,
    input  logic                  sdr_rdy,
    input  logic [sdr_data_w-1:0] sdr_dout,

    input  logic                  vpulse,
    input  logic                  pause_rq,
    input  logic                  kick_harness,
    input  logic [3:0]            coin,
    input  logic [3:0]            start_buttons,
    input  logic [9:0]            p1_in,
    input  logic [9:0]            p2_in,
    input  logic [9:0]            p3_in,
    input  logic [9:0]            p4_in,
    input  logic [23:0]           dip_sw,
    output logic                  cpu_paused,
    output logic [7:0]            sys_flags
);

    logic                  miss;
    logic                  fill_write;
    logic                  rom_read;
    logic [sdr_addr_w-1:0] rom_addr;
    logic [cpu_data_w-1:0] rom_word;
    logic [3:0]            bank;

    m92_cpu_stall_fsm u_stall_fsm (
        .clk_sys    (clk_sys),
        .reset_n    (reset_n),
        .miss       (miss),
        .sdr_rdy    (sdr_rdy),
        .bus_active (mem_read | mem_write | io_read | io_write),
        .vpulse     (vpulse),
        .pause_rq   (pause_rq),
        .sdr_req    (sdr_req),
        .fill_write (fill_write),
        .cpu_stall  (cpu_stall),
        .cpu_paused (cpu_paused)
    );

    m92_cpu_cen u_cpu_cen (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .cpu_stall (cpu_stall),
        .cpu_ce    (cpu_ce),
        .cpu_ce_4x (cpu_ce_4x)
    );

    m92_rom_cache u_rom_cache (
        .clk_sys    (clk_sys),
        .reset_n    (reset_n),
        .rom_read   (rom_read),
        .rom_addr   (rom_addr),
        .fill_write (fill_write),
        .sdr_dout   (sdr_dout),
        .miss       (miss),
        .sdr_addr   (sdr_addr),
        .rom_word   (rom_word)
    );

    m92_mem_map u_mem_map (
        .clk_sys   (clk_sys),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata),
        .bank      (bank),
        .rom_word  (rom_word),
        .rom_read  (rom_read),
        .rom_addr  (rom_addr),
        .mem_rdata (mem_rdata)
    );

    m92_io_ports u_io_ports (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .io_write      (io_write),
        .io_addr       (io_addr),
        .io_wdata      (io_wdata),
        .kick_harness  (kick_harness),
        .coin          (coin),
        .start_buttons (start_buttons),
        .p1_in         (p1_in),
        .p2_in         (p2_in),
        .p3_in         (p3_in),
        .p4_in         (p4_in),
        .dip_sw        (dip_sw),
        .io_rdata      (io_rdata),
        .bank          (bank),
        .sys_flags     (sys_flags)
    );

endmodule

/* verilog/m92_bus_pkg.sv */
// Memory map, ROM cache geometry, bus widths and the stall FSM states
package m92_bus_pkg;

    // ========================================================================
    // Bus widths
    // ========================================================================
    localparam int cpu_addr_w = 20;
    localparam int cpu_data_w = 16;
    localparam int sdr_addr_w = 25;
    localparam int sdr_data_w = 64;

    // ========================================================================
    // ROM cache geometry
    // ========================================================================
    localparam int cache_lines_log2 = 5;
    localparam int words_per_line = 4;
    localparam int word_sel_w = $clog2(words_per_line);
    localparam int line_off_w = word_sel_w + 1;
    localparam int cache_idx_w = cache_lines_log2 + word_sel_w;
    localparam int tag_lsb = line_off_w + cache_lines_log2;
    localparam int tag_w = sdr_addr_w - tag_lsb;

    // ========================================================================
    // CPU memory map
    // ========================================================================
    localparam int rom_top = 'h80000;
    localparam int bank_base = 'h80000;
    localparam int bank_size = 'h20000;
    localparam int ram_base = 'hE0000;
    localparam int ram_words_log2 = 15;
    localparam int ram_top = ram_base + 2 * (2 ** ram_words_log2);

    // CPU hold reasons
    typedef enum logic [1:0] {
        IDLE,
        FILL_WAIT,
        FILL_DONE,
        PAUSED
    } stall_state_e;

endpackage

/* verilog/m92_cpu_cen.sv */
// CPU clock enables, divide by 4 of the unstalled system clock cycles
module m92_cpu_cen (
    input  logic clk_sys,
    input  logic reset_n,
    input  logic cpu_stall,
    output logic cpu_ce,
    output logic cpu_ce_4x
);

    logic [1:0] ce_count;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            ce_count <= 2'd0;
            cpu_ce <= 1'b0;
            cpu_ce_4x <= 1'b0;
        end else begin
            cpu_ce_4x <= !cpu_stall;
            // Main enable on the last count of each group of four
            cpu_ce <= !cpu_stall && (&ce_count);
            if (!cpu_stall) begin
                ce_count <= ce_count + 2'd1;
            end
        end
    end

endmodule

/* verilog/m92_cpu_stall_fsm.sv */
// Stall FSM for ROM cache fills and vertical-pulse pausing
module m92_cpu_stall_fsm
    import m92_bus_pkg::*;
(
    input  logic clk_sys,
    input  logic reset_n,
    input  logic miss,
    input  logic sdr_rdy,
    input  logic bus_active,
    input  logic vpulse,
    input  logic pause_rq,
    output logic sdr_req,
    output logic fill_write,
    output logic cpu_stall,
    output logic cpu_paused
);

    stall_state_e state;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
            sdr_req <= 1'b0;
        end else begin
            sdr_req <= 1'b0;
            case (state)
                IDLE: begin
                    // A fill wins over a pause request
                    if (miss) begin
                        sdr_req <= 1'b1;
                        state <= FILL_WAIT;
                    end else if (pause_rq && !bus_active && vpulse) begin
                        state <= PAUSED;
                    end
                end
                FILL_WAIT: begin
                    if (sdr_rdy) begin
                        state <= FILL_DONE;
                    end
                end
                FILL_DONE: begin
                    // Lets the read word register pick up the new line
                    state <= IDLE;
                end
                PAUSED: begin
                    if (!pause_rq && !vpulse) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign fill_write = (state == FILL_WAIT) && sdr_rdy;
    assign cpu_stall = (state != IDLE);
    assign cpu_paused = (state == PAUSED);

endmodule

/* verilog/m92_io_pkg.sv */
// I/O port numbers and bit positions of the flags word
package m92_io_pkg;

    // Port numbers as seen on the CPU I/O bus, always the even address
    typedef enum logic [7:0] {
        SW_P1_P2 = 8'h00,
        FLAGS    = 8'h02,
        DIP_LOW  = 8'h04,
        SW_P3_P4 = 8'h06,
        BANK_SEL = 8'h20
    } io_port_e;

    // Same port as FLAGS, write side
    localparam io_port_e SYS_FLAGS = FLAGS;

    // ========================================================================
    // Flags word layout
    // ========================================================================
    localparam int flag_start_lsb = 0;
    localparam int flag_coin_lsb = 2;
    localparam int flag_dma_idle_bit = 7;
    localparam int flag_dip_lsb = 8;

endpackage

/* verilog/m92_io_ports.sv */
// I/O ports with switch mapping, flags, read mux, bank and system flag registers
module m92_io_ports
    import m92_io_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset_n,
    input  logic        io_write,
    input  logic [7:0]  io_addr,
    input  logic [7:0]  io_wdata,
    input  logic        kick_harness,
    input  logic [3:0]  coin,
    input  logic [3:0]  start_buttons,
    input  logic [9:0]  p1_in,
    input  logic [9:0]  p2_in,
    input  logic [9:0]  p3_in,
    input  logic [9:0]  p4_in,
    input  logic [23:0] dip_sw,
    output logic [7:0]  io_rdata,
    output logic [3:0]  bank,
    output logic [7:0]  sys_flags
);

    logic [7:0]  sw_p1;
    logic [7:0]  sw_p2;
    logic [7:0]  sw_p3;
    logic [7:0]  sw_p4;
    logic [15:0] flags;
    logic [15:0] io16;

    // One player byte in board order, buttons 1 and 2 on top and the directions below
    function automatic logic [7:0] player_byte(input logic [9:0] p, input logic b5,
                                               input logic b4);
        player_byte = {p[4], p[5], b5, b4, p[3:0]};
    endfunction

    // ========================================================================
    // Active-high switch mapping that the port words invert
    // ========================================================================
    always_comb begin
        if (kick_harness) begin
            sw_p1 = player_byte(p1_in, p1_in[6], 1'b0);
            sw_p2 = player_byte(p2_in, p2_in[6], 1'b0);
            sw_p3 = 8'h00;
            // Kick buttons of players 1 and 2 take the player 4 byte
            sw_p4 = {p2_in[9], p2_in[8], p2_in[7], 1'b0, p1_in[9], p1_in[8], p1_in[7], 1'b0};
        end else begin
            sw_p1 = player_byte(p1_in, 1'b0, 1'b0);
            sw_p2 = player_byte(p2_in, 1'b0, 1'b0);
            sw_p3 = player_byte(p3_in, coin[2], start_buttons[2]);
            sw_p4 = player_byte(p4_in, coin[3], start_buttons[3]);
        end
    end

    always_comb begin
        flags = 16'hFFFF;
        flags[flag_start_lsb +: 2] = ~start_buttons[1:0];
        flags[flag_coin_lsb +: 2] = ~coin[1:0];
        flags[flag_dma_idle_bit] = 1'b1;
        flags[flag_dip_lsb +: 8] = ~dip_sw[23:16];
    end

    // Read mux by even port number with the odd address picking the high byte
    always_comb begin
        case (io_port_e'({io_addr[7:1], 1'b0}))
            SW_P1_P2: io16 = {~sw_p2, ~sw_p1};
            FLAGS:    io16 = flags;
            DIP_LOW:  io16 = ~dip_sw[15:0];
            SW_P3_P4: io16 = {~sw_p4, ~sw_p3};
            default:  io16 = 16'hFFFF;
        endcase
        io_rdata = io_addr[0] ? io16[15:8] : io16[7:0];
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags <= 8'h00;
            bank <= 4'h0;
        end else if (io_write) begin
            if (io_addr == SYS_FLAGS) begin
                sys_flags <= io_wdata;
            end
            if (io_addr == BANK_SEL) begin
                bank <= io_wdata[3:0];
            end
        end
    end

endmodule

/* verilog/m92_mem_map.sv */
// CPU memory decode, ROM bank window, work RAM and read data mux
module m92_mem_map
    import m92_bus_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [cpu_addr_w-1:0] mem_addr,
    input  logic [1:0]            mem_sel,
    input  logic [cpu_data_w-1:0] mem_wdata,
    input  logic [3:0]            bank,
    input  logic [cpu_data_w-1:0] rom_word,
    output logic                  rom_read,
    output logic [sdr_addr_w-1:0] rom_addr,
    output logic [cpu_data_w-1:0] mem_rdata
);

    logic                      rom_area;
    logic                      bank_area;
    logic                      ram_area;
    logic [cpu_data_w-1:0]     word_out;
    logic [1:0]                lane_we;
    logic [ram_words_log2-1:0] ram_idx;
    logic [cpu_data_w-1:0]     ram_q;
    logic [cpu_data_w-1:0]     src_word;
    logic                      sel_ram_q;
    logic                      sel_rom_q;
    logic                      odd_q;

    assign rom_area = mem_addr < cpu_addr_w'(rom_top);
    assign bank_area = (mem_addr >= cpu_addr_w'(bank_base))
                    && (mem_addr < cpu_addr_w'(bank_base + bank_size));
    assign ram_area = (mem_addr >= cpu_addr_w'(ram_base)) && (mem_addr < cpu_addr_w'(ram_top));

    always_comb begin
        if (bank_area) begin
            rom_addr = sdr_addr_w'(bank_base) + sdr_addr_w'(bank) * sdr_addr_w'(bank_size)
                     + sdr_addr_w'(mem_addr - cpu_addr_w'(bank_base));
        end else begin
            rom_addr = sdr_addr_w'(mem_addr);
        end
    end

    assign rom_read = mem_read && (rom_area || bank_area);

    // ========================================================================
    // Work RAM, one array per byte lane
    // ========================================================================
    // Odd byte writes go to the high lane, enabled by sel bit 0
    assign word_out = mem_addr[0] ? {mem_wdata[7:0], 8'h00} : mem_wdata;
    assign lane_we = (mem_write && ram_area) ? (mem_addr[0] ? {mem_sel[0], 1'b0} : mem_sel)
                                             : 2'b00;
    assign ram_idx = mem_addr[ram_words_log2:1];

    for (genvar l = 0; l < 2; l++) begin : g_lane
        logic [7:0] lane_mem [2**ram_words_log2];
        logic [7:0] lane_q;

        always_ff @(posedge clk_sys) begin
            if (lane_we[l]) begin
                lane_mem[ram_idx] <= word_out[l*8 +: 8];
            end
            if (mem_read) begin
                lane_q <= lane_mem[ram_idx];
            end
        end
    end

    assign ram_q = {g_lane[1].lane_q, g_lane[0].lane_q};

    // Source of the word, as decoded at the read strobe
    always_ff @(posedge clk_sys) begin
        if (mem_read) begin
            sel_ram_q <= ram_area;
            sel_rom_q <= rom_area || bank_area;
            odd_q <= mem_addr[0];
        end
    end

    assign src_word = sel_ram_q ? ram_q : (sel_rom_q ? rom_word : 16'hFFFF);
    assign mem_rdata = odd_q ? {8'h00, src_word[15:8]} : src_word;

endmodule

/* verilog/m92_rom_cache.sv */
// Direct-mapped ROM cache with tags, line data, hit check, line fill and read word
module m92_rom_cache
    import m92_bus_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset_n,
    input  logic                  rom_read,
    input  logic [sdr_addr_w-1:0] rom_addr,
    input  logic                  fill_write,
    input  logic [sdr_data_w-1:0] sdr_dout,
    output logic                  miss,
    output logic [sdr_addr_w-1:0] sdr_addr,
    output logic [cpu_data_w-1:0] rom_word
);

    logic [tag_w-1:0]      tag_mem [2**cache_lines_log2];
    logic [cpu_data_w-1:0] data_mem [2**cache_idx_w];
    logic [2**cache_lines_log2-1:0] line_valid;

    logic [cache_lines_log2-1:0] rd_line;
    logic [tag_w-1:0]            rd_tag;
    logic [cache_lines_log2-1:0] fill_line;
    logic [cache_idx_w-1:0]      word_idx;
    logic [cache_idx_w-1:0]      word_idx_q;

    // ========================================================================
    // Hit check
    // ========================================================================
    assign rd_line = rom_addr[tag_lsb-1 -: cache_lines_log2];
    assign rd_tag = rom_addr[sdr_addr_w-1:tag_lsb];
    assign fill_line = sdr_addr[tag_lsb-1 -: cache_lines_log2];

    assign miss = rom_read && !(line_valid[rd_line] && (tag_mem[rd_line] == rd_tag));

    // A new strobe reads straight away and otherwise the last read is followed
    assign word_idx = rom_read ? rom_addr[cache_idx_w:1] : word_idx_q;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            line_valid <= '0;
        end else if (fill_write) begin
            line_valid[fill_line] <= 1'b1;
        end
    end

    // ========================================================================
    // Line fill and read word
    // ========================================================================
    always_ff @(posedge clk_sys) begin
        if (miss) begin
            sdr_addr <= {rom_addr[sdr_addr_w-1:line_off_w], line_off_w'(0)};
        end
        if (rom_read) begin
            word_idx_q <= rom_addr[cache_idx_w:1];
        end
        if (fill_write) begin
            tag_mem[fill_line] <= sdr_addr[sdr_addr_w-1:tag_lsb];
            // Word n of the line comes in bits 16n and up
            for (int n = 0; n < words_per_line; n++) begin
                data_mem[{fill_line, word_sel_w'(n)}] <= sdr_dout[n*cpu_data_w +: cpu_data_w];
            end
        end
        rom_word <= data_mem[word_idx];
    end

endmodule

/* vlog.f */
verilog/m92_bus_pkg.sv
verilog/m92_io_pkg.sv
verilog/m92_cpu_stall_fsm.sv
verilog/m92_cpu_cen.sv
verilog/m92_rom_cache.sv
verilog/m92_mem_map.sv
verilog/m92_io_ports.sv
verilog/m92_bus_ctrl.sv
testbench/tb_m92_bus_ctrl.sv
